//--- src/mem_defs.svh
// cache geometry, I/O decode bits and bus widths
// shared by the memory side RTL and the testbench
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// instruction cache shape
`define BLOCK_WIDTH 1   // log2 instructions per block
`define CACHE_WIDTH 8   // log2 blocks
`define BLOCK_BYTES 8
`define BLOCK_NUM   (1 << `CACHE_WIDTH)

// byte offset bits inside one block
`define OFFSET_BITS (`BLOCK_WIDTH + 2)

// I/O window, mem_a[17:16] == 2'b11
`define IO_SEL_HI    17
`define IO_SEL_LO    16
`define IO_PORT_ADDR 32'h30000

// RAM bus lane width
`define BYTE_WIDTH 8

`endif

//--- src/mem_pkg.sv
// types for the memory subsystem: bus vectors, cache fields,
// load/store width codes and controller state
package mem_pkg;

  typedef logic [31:0] addr_t;         // byte address
  typedef logic [31:0] word_t;
  typedef logic [7:0]  byte_t;         // RAM bus lane
  typedef logic [63:0] block_t;        // two instructions
  typedef logic [7:0]  cache_index_t;
  typedef logic [20:0] cache_tag_t;    // address bits above the index
  typedef logic [2:0]  byte_cnt_t;     // byte position in an access

  // funct3 of RV32I loads and stores
  typedef enum logic [2:0] {
    LS_B  = 3'd0,
    LS_H  = 3'd1,
    LS_W  = 3'd2,
    LS_BU = 3'd4,
    LS_HU = 3'd5
  } ls_width_e;

  typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE} mem_state_e;

  // who got the bus last time
  typedef enum logic {SERVE_LSB, SERVE_ICACHE} serve_e;

endpackage

//--- src/mem_ctrl.sv
// RAM bus controller: arbitration between icache refill and load/store,
// byte sequencing, I/O write hold-off and rdy_in pause handling
`include "mem_defs.svh"

module mem_ctrl (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                rdy_in,
  input  logic                io_buffer_full,
  input  logic                refill_req,
  input  mem_pkg::addr_t      refill_addr,
  input  logic                ls_en,
  input  logic                ls_wr,
  input  mem_pkg::ls_width_e  ls_width,
  input  mem_pkg::addr_t      ls_addr,
  output mem_pkg::addr_t      mem_a,
  output logic                mem_wr,
  output logic                refill_we,
  output logic                refill_done,
  output logic                lsu_capture,
  output logic                ls_rdone,
  output logic                ls_wdone,
  output mem_pkg::byte_cnt_t  byte_idx
);

  mem_pkg::mem_state_e state;
  mem_pkg::serve_e     last_serve;      // also the current owner while busy

  // pending load/store
  logic                ls_pend;
  logic                ls_wr_q;
  mem_pkg::ls_width_e  ls_width_q;
  mem_pkg::addr_t      ls_addr_q;

  mem_pkg::addr_t      base_addr;
  mem_pkg::addr_t      mem_a_q;
  mem_pkg::byte_cnt_t  last_idx;
  mem_pkg::byte_cnt_t  iss_idx;         // next byte to put on mem_a
  mem_pkg::byte_cnt_t  cap_idx;         // byte on mem_din, or on the bus for writes
  mem_pkg::byte_cnt_t  ls_last;
  logic                iss_done;
  logic                addr_live;       // mem_a holds a read address this cycle
  logic                data_valid;      // mem_din holds a requested byte
  logic                wr_q;
  logic                paused_q;
  logic                refill_done_q;
  logic                rdone_q;
  logic                wdone_q;
  logic                ls_is_io;
  logic                ic_ok;
  logic                ls_ok;
  logic                pick_ls;
  logic                pick_ic;
  logic                cap_en;

  always_comb begin
    case (ls_width_q)
      mem_pkg::LS_H, mem_pkg::LS_HU: ls_last = 3'd1;
      mem_pkg::LS_W:                 ls_last = 3'd3;
      default:                       ls_last = 3'd0;
    endcase
  end

  assign ls_is_io = (ls_addr_q[`IO_SEL_HI:`IO_SEL_LO] == 2'b11);
  assign ic_ok    = refill_req && !refill_done_q;  // cache drops its request a cycle late
  assign ls_ok    = ls_pend && !(ls_wr_q && ls_is_io && io_buffer_full);
  assign pick_ls  = ls_ok && (!ic_ok || last_serve == mem_pkg::SERVE_ICACHE);
  assign pick_ic  = ic_ok && !pick_ls;

  // first cycle after a pause carries a stale byte
  assign cap_en = (state == mem_pkg::ST_READ) && data_valid && rdy_in && !paused_q;

  assign mem_a       = mem_a_q;
  assign mem_wr      = wr_q && rdy_in;
  assign byte_idx    = cap_idx;
  assign refill_we   = cap_en && (last_serve == mem_pkg::SERVE_ICACHE);
  assign lsu_capture = cap_en && (last_serve == mem_pkg::SERVE_LSB);
  assign refill_done = refill_done_q && rdy_in;
  assign ls_rdone    = rdone_q && rdy_in;
  assign ls_wdone    = wdone_q && rdy_in;

  // request latch, taken even while paused
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ls_pend <= 1'b0;
    end else if (ls_en) begin
      ls_pend    <= 1'b1;
      ls_wr_q    <= ls_wr;
      ls_width_q <= ls_width;
      ls_addr_q  <= ls_addr;
    end else if (rdy_in && state == mem_pkg::ST_IDLE && pick_ls) begin
      ls_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) paused_q <= 1'b0;
    else        paused_q <= !rdy_in;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state         <= mem_pkg::ST_IDLE;
      last_serve    <= mem_pkg::SERVE_ICACHE;
      mem_a_q       <= '0;
      wr_q          <= 1'b0;
      addr_live     <= 1'b0;
      data_valid    <= 1'b0;
      iss_done      <= 1'b0;
      iss_idx       <= '0;
      cap_idx       <= '0;
      last_idx      <= '0;
      refill_done_q <= 1'b0;
      rdone_q       <= 1'b0;
      wdone_q       <= 1'b0;
    end else if (rdy_in) begin
      refill_done_q <= 1'b0;
      rdone_q       <= 1'b0;
      wdone_q       <= 1'b0;
      unique case (state)
        mem_pkg::ST_IDLE: begin
          cap_idx <= '0;
          iss_idx <= 3'd1;
          if (pick_ls) begin
            last_serve <= mem_pkg::SERVE_LSB;
            base_addr  <= ls_addr_q;
            mem_a_q    <= ls_addr_q;
            last_idx   <= ls_last;
            iss_done   <= (ls_last == '0);
            if (ls_wr_q) begin
              state   <= mem_pkg::ST_WRITE;
              wr_q    <= 1'b1;
              wdone_q <= (ls_last == '0);  // single byte store
            end else begin
              state     <= mem_pkg::ST_READ;
              addr_live <= 1'b1;
            end
          end else if (pick_ic) begin
            last_serve <= mem_pkg::SERVE_ICACHE;
            base_addr  <= refill_addr;
            mem_a_q    <= refill_addr;
            last_idx   <= mem_pkg::byte_cnt_t'(`BLOCK_BYTES - 1);
            iss_done   <= 1'b0;
            state      <= mem_pkg::ST_READ;
            addr_live  <= 1'b1;
          end
        end
        mem_pkg::ST_READ: begin
          if (paused_q) begin
            // byte in flight was lost, issue it again
            mem_a_q    <= base_addr + 32'(cap_idx);
            addr_live  <= 1'b1;
            data_valid <= 1'b0;
            iss_idx    <= cap_idx + 3'd1;
            iss_done   <= (cap_idx == last_idx);
          end else begin
            data_valid <= addr_live;
            if (!iss_done) begin
              mem_a_q   <= base_addr + 32'(iss_idx);
              addr_live <= 1'b1;
              iss_idx   <= iss_idx + 3'd1;
              iss_done  <= (iss_idx == last_idx);
            end else begin
              addr_live <= 1'b0;
            end
            if (data_valid) begin
              cap_idx <= cap_idx + 3'd1;
              if (cap_idx == last_idx) begin
                state      <= mem_pkg::ST_IDLE;
                mem_a_q    <= '0;
                data_valid <= 1'b0;
                if (last_serve == mem_pkg::SERVE_ICACHE) refill_done_q <= 1'b1;
                else                                     rdone_q       <= 1'b1;
              end
            end
          end
        end
        mem_pkg::ST_WRITE: begin
          if (cap_idx == last_idx) begin
            state   <= mem_pkg::ST_IDLE;
            wr_q    <= 1'b0;
            mem_a_q <= '0;
          end else begin
            cap_idx <= cap_idx + 3'd1;
            mem_a_q <= base_addr + 32'(cap_idx + 3'd1);
            wdone_q <= (cap_idx + 3'd1 == last_idx);  // pulse with the last write
          end
        end
        default: state <= mem_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

//--- src/ins_cache.sv
// direct-mapped instruction cache, 256 blocks of two instructions,
// with a byte-wise refill buffer fed from the RAM bus
`include "mem_defs.svh"

module ins_cache (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                rdy_in,
  input  logic                fetch_en,
  input  mem_pkg::addr_t      fetch_addr,
  output logic                fetch_valid,
  output mem_pkg::word_t      fetch_inst,
  output logic                refill_req,
  output mem_pkg::addr_t      refill_addr,
  input  logic                refill_we,
  input  logic                refill_done,
  input  mem_pkg::byte_cnt_t  byte_idx,
  input  mem_pkg::byte_t      mem_din
);

  logic [`BLOCK_NUM-1:0] valid_bits;
  mem_pkg::cache_tag_t   tags   [`BLOCK_NUM];
  mem_pkg::block_t       blocks [`BLOCK_NUM];

  mem_pkg::block_t       blk_buf;     // refill assembly
  mem_pkg::block_t       hit_blk;
  mem_pkg::addr_t        miss_addr;
  mem_pkg::cache_index_t idx;
  mem_pkg::cache_index_t miss_idx;
  mem_pkg::cache_tag_t   tag;
  mem_pkg::cache_tag_t   miss_tag;
  logic [`BLOCK_WIDTH-1:0] word_sel;
  logic [`BLOCK_WIDTH-1:0] miss_sel;
  mem_pkg::word_t        inst_q;
  logic                  hit;
  logic                  refilling;
  logic                  valid_q;

  // split of the held fetch address
  assign idx      = fetch_addr[`OFFSET_BITS+`CACHE_WIDTH-1:`OFFSET_BITS];
  assign tag      = fetch_addr[31:`OFFSET_BITS+`CACHE_WIDTH];
  assign word_sel = fetch_addr[`OFFSET_BITS-1:2];

  assign miss_idx = miss_addr[`OFFSET_BITS+`CACHE_WIDTH-1:`OFFSET_BITS];
  assign miss_tag = miss_addr[31:`OFFSET_BITS+`CACHE_WIDTH];
  assign miss_sel = miss_addr[`OFFSET_BITS-1:2];

  assign hit_blk = blocks[idx];
  // no lookups during a refill, the requester holds its address
  assign hit = fetch_en && !refilling && valid_bits[idx] && (tags[idx] == tag);

  assign refill_req  = refilling;
  assign refill_addr = {miss_addr[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
  assign fetch_valid = valid_q && rdy_in;
  assign fetch_inst  = inst_q;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_bits <= '0;
      refilling  <= 1'b0;
      valid_q    <= 1'b0;
    end else if (rdy_in) begin
      valid_q <= 1'b0;
      if (refill_done) begin
        valid_bits[miss_idx] <= 1'b1;
        refilling            <= 1'b0;
        valid_q              <= 1'b1;   // answer the missed fetch
      end else if (hit) begin
        valid_q <= 1'b1;
      end else if (fetch_en && !refilling) begin
        refilling <= 1'b1;              // miss
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (refill_we) begin
        blk_buf[`BYTE_WIDTH*byte_idx +: `BYTE_WIDTH] <= mem_din;
      end
      if (refill_done) begin
        tags[miss_idx]   <= miss_tag;
        blocks[miss_idx] <= blk_buf;
        inst_q           <= blk_buf[32*miss_sel +: 32];
      end else if (hit) begin
        inst_q <= hit_blk[32*word_sel +: 32];
      end
      if (fetch_en && !refilling && !hit) begin
        miss_addr <= fetch_addr;
      end
    end
  end

endmodule

//--- src/lsu_datapath.sv
// load/store data path: store byte lane select and
// little-endian load assembly with sign or zero extension
`include "mem_defs.svh"

module lsu_datapath (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                rdy_in,
  input  logic                ls_en,
  input  mem_pkg::ls_width_e  ls_width,
  input  mem_pkg::word_t      ls_wdata,
  input  mem_pkg::byte_cnt_t  byte_idx,
  input  logic                lsu_capture,
  input  logic                ls_rdone,
  input  mem_pkg::byte_t      mem_din,
  output mem_pkg::byte_t      mem_dout,
  output mem_pkg::word_t      ls_rdata
);

  mem_pkg::ls_width_e width_q;
  mem_pkg::word_t     wdata_q;
  mem_pkg::word_t     rdata_q;   // bytes gathered so far
  logic [1:0]         lane;

  assign lane = byte_idx[1:0];   // a word never spans more than 4 bytes

  // operands of the strobed access
  always_ff @(posedge clk_in) begin
    if (ls_en) begin
      width_q <= ls_width;
      wdata_q <= ls_wdata;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rdata_q <= '0;
    end else if (rdy_in) begin
      if (ls_rdone) begin
        rdata_q <= '0;           // result handed over
      end else if (lsu_capture) begin
        rdata_q[`BYTE_WIDTH*lane +: `BYTE_WIDTH] <= mem_din;
      end
    end
  end

  assign mem_dout = wdata_q[`BYTE_WIDTH*lane +: `BYTE_WIDTH];

  always_comb begin
    case (width_q)
      mem_pkg::LS_B:  ls_rdata = {{24{rdata_q[7]}}, rdata_q[7:0]};
      mem_pkg::LS_H:  ls_rdata = {{16{rdata_q[15]}}, rdata_q[15:0]};
      mem_pkg::LS_BU: ls_rdata = {24'b0, rdata_q[7:0]};
      mem_pkg::LS_HU: ls_rdata = {16'b0, rdata_q[15:0]};
      default:        ls_rdata = rdata_q;  // full word
    endcase
  end

endmodule

//--- src/mem_subsystem.sv
// memory subsystem top: controller, instruction cache and
// load/store data path sharing one byte-wide RAM bus
`include "mem_defs.svh"

module mem_subsystem (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                rdy_in,        // pause when low
  // RAM bus
  input  mem_pkg::byte_t      mem_din,
  output mem_pkg::byte_t      mem_dout,
  output mem_pkg::addr_t      mem_a,
  output logic                mem_wr,        // 1 for write
  input  logic                io_buffer_full,
  // fetch side
  input  logic                fetch_en,
  input  mem_pkg::addr_t      fetch_addr,
  output logic                fetch_valid,
  output mem_pkg::word_t      fetch_inst,
  // load/store side
  input  logic                ls_en,
  input  logic                ls_wr,
  input  mem_pkg::ls_width_e  ls_width,
  input  mem_pkg::addr_t      ls_addr,
  input  mem_pkg::word_t      ls_wdata,
  output logic                ls_rdone,
  output logic                ls_wdone,
  output mem_pkg::word_t      ls_rdata
);

  logic               refill_req;
  mem_pkg::addr_t     refill_addr;
  logic               refill_we;
  logic               refill_done;
  logic               lsu_capture;
  mem_pkg::byte_cnt_t byte_idx;

  mem_ctrl u_mem_ctrl (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .io_buffer_full (io_buffer_full),
    .refill_req     (refill_req),
    .refill_addr    (refill_addr),
    .ls_en          (ls_en),
    .ls_wr          (ls_wr),
    .ls_width       (ls_width),
    .ls_addr        (ls_addr),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr),
    .refill_we      (refill_we),
    .refill_done    (refill_done),
    .lsu_capture    (lsu_capture),
    .ls_rdone       (ls_rdone),
    .ls_wdone       (ls_wdone),
    .byte_idx       (byte_idx)
  );

  ins_cache u_ins_cache (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .fetch_en    (fetch_en),
    .fetch_addr  (fetch_addr),
    .fetch_valid (fetch_valid),
    .fetch_inst  (fetch_inst),
    .refill_req  (refill_req),
    .refill_addr (refill_addr),
    .refill_we   (refill_we),
    .refill_done (refill_done),
    .byte_idx    (byte_idx),
    .mem_din     (mem_din)
  );

  lsu_datapath u_lsu_datapath (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .ls_en       (ls_en),
    .ls_width    (ls_width),
    .ls_wdata    (ls_wdata),
    .byte_idx    (byte_idx),
    .lsu_capture (lsu_capture),
    .ls_rdone    (ls_rdone),
    .mem_din     (mem_din),
    .mem_dout    (mem_dout),
    .ls_rdata    (ls_rdata)
  );

endmodule

//--- sim/tb_clock.sv
// free-running testbench clock, period 8
module tb_clock (
  output logic clk_in
);

  initial clk_in = 1'b0;

  always #4 clk_in = ~clk_in;  // half period

endmodule

//--- sim/ram_model.sv
// byte-wide RAM with next-cycle read data and a log of I/O port writes
`include "mem_defs.svh"

module ram_model (
  input  logic            clk_in,
  input  mem_pkg::addr_t  mem_a,
  input  logic            mem_wr,
  input  mem_pkg::byte_t  mem_dout,
  output mem_pkg::byte_t  mem_din
);

  mem_pkg::byte_t mem [0:65535];  // 64 KiB, upper address bits ignored
  mem_pkg::byte_t io_last;        // last byte sent to the output port
  int             io_count;
  logic           io_sel;

  assign io_sel = (mem_a[`IO_SEL_HI:`IO_SEL_LO] == 2'b11);

  initial begin
    mem_din  = '0;
    io_last  = '0;
    io_count = 0;
  end

  always @(posedge clk_in) begin
    mem_din <= mem[mem_a[15:0]];
    if (mem_wr) begin
      if (mem_a == `IO_PORT_ADDR) begin
        io_last  <= mem_dout;
        io_count <= io_count + 1;
      end else if (!io_sel) begin
        mem[mem_a[15:0]] <= mem_dout;
      end
    end
  end

endmodule

//--- sim/mem_tb.sv
// testbench for the memory subsystem: LFSR-filled RAM with a reference copy,
// fetch, load/store, I/O hold-off, rdy_in pause and overlap checks
`include "mem_defs.svh"

module mem_tb;

  localparam int NUM_RAND   = 24;                          // load/store/load rounds
  localparam int NUM_OPS    = 5 + 3 * NUM_RAND + 1 + 5 * 4;
  localparam int MAX_CYCLES = 10 + 60 * NUM_OPS;           // refill behind a word access plus a pause

  logic clk_in, rst_in, rdy_in, io_buffer_full;
  logic fetch_en, fetch_valid, ls_en, ls_wr, ls_rdone, ls_wdone, mem_wr;
  mem_pkg::addr_t     fetch_addr, ls_addr, mem_a;
  mem_pkg::word_t     fetch_inst, ls_wdata, ls_rdata;
  mem_pkg::byte_t     mem_din, mem_dout;
  mem_pkg::ls_width_e ls_width;
  mem_pkg::byte_t     ref_mem [0:65535];
  logic [31:0]        lfsr_state = 32'h492;
  int                 cycles = 0;

  tb_clock u_clock (.*);
  ram_model ram (.*);
  mem_subsystem DUT (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // RV32I load result from the reference bytes
  function automatic mem_pkg::word_t expect_load(input mem_pkg::ls_width_e w, input mem_pkg::addr_t a);
    mem_pkg::word_t raw;
    raw = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
    case (w)
      mem_pkg::LS_B:  return {{24{raw[7]}}, raw[7:0]};
      mem_pkg::LS_H:  return {{16{raw[15]}}, raw[15:0]};
      mem_pkg::LS_BU: return {24'h0, raw[7:0]};
      mem_pkg::LS_HU: return {16'h0, raw[15:0]};
      default:        return raw;
    endcase
  endfunction

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Fail %s got %h expected %h", name, got, exp);
    abort_run();
  endtask

  // hit_mode 0 wants a miss, 1 a hit, 2 either
  task automatic do_fetch(input mem_pkg::addr_t a, input int hit_mode);
    int n;
    mem_pkg::word_t exp;
    exp = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
    @(posedge clk_in);
    fetch_en   <= 1'b1;
    fetch_addr <= a;
    @(negedge clk_in);
    n = 1;
    while (!fetch_valid) begin
      @(negedge clk_in);
      n++;
    end
    assert (fetch_inst == exp) else fail_value("fetch_inst", fetch_inst, exp);
    if (hit_mode != 2) begin
      assert ((n == 2) == (hit_mode == 1)) else begin
        $display("fetch at %h answered after %0d cycles, wrong hit or miss timing", a, n - 1);
        abort_run();
      end
    end
    @(posedge clk_in);
    fetch_en <= 1'b0;
    repeat (2) @(posedge clk_in);  // let the repeat hit drain
  endtask

  task automatic do_load(input mem_pkg::ls_width_e w, input mem_pkg::addr_t a);
    mem_pkg::word_t exp;
    exp = expect_load(w, a);
    @(posedge clk_in);
    ls_en    <= 1'b1;
    ls_wr    <= 1'b0;
    ls_width <= w;
    ls_addr  <= a;
    @(posedge clk_in);
    ls_en <= 1'b0;
    @(negedge clk_in);
    while (!ls_rdone) @(negedge clk_in);
    assert (ls_rdata == exp) else fail_value("ls_rdata", ls_rdata, exp);
  endtask

  task automatic do_store(input mem_pkg::ls_width_e w, input mem_pkg::addr_t a,
                          input mem_pkg::word_t d);
    int nb;
    nb = (w == mem_pkg::LS_W) ? 4 : (w == mem_pkg::LS_H) ? 2 : 1;
    @(posedge clk_in);
    ls_en    <= 1'b1;
    ls_wr    <= 1'b1;
    ls_width <= w;
    ls_addr  <= a;
    ls_wdata <= d;
    @(posedge clk_in);
    ls_en <= 1'b0;
    @(negedge clk_in);
    while (!ls_wdone) @(negedge clk_in);
    @(negedge clk_in);             // last byte lands on the edge after ls_wdone
    if (a[`IO_SEL_HI:`IO_SEL_LO] != 2'b11) begin
      for (int i = 0; i < nb; i++) ref_mem[a + i] = d[8*i +: 8];
      for (int i = -1; i <= nb; i++) begin  // neighbours must not move
        assert (ram.mem[a + i] === ref_mem[a + i])
          else fail_value($sformatf("ram.mem[%h]", a + i), ram.mem[a + i], ref_mem[a + i]);
      end
    end
  endtask

  task automatic pause_bus(input int delay, input int len);
    repeat (delay) @(posedge clk_in);
    rdy_in <= 1'b0;
    repeat (len) @(posedge clk_in);
    rdy_in <= 1'b1;
  endtask

  always @(posedge clk_in) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles, an access never completed", cycles);
      abort_run();
    end
  end

  // bus rules, sampled mid-cycle
  always @(negedge clk_in) begin
    if (!rst_in && !rdy_in) begin
      assert (!mem_wr && !fetch_valid && !ls_rdone && !ls_wdone) else begin
        $display("write or done pulse seen while rdy_in was low");
        abort_run();
      end
    end
    if (!rst_in && mem_wr && mem_a == `IO_PORT_ADDR) begin
      assert (!io_buffer_full) else begin
        $display("I/O port written while io_buffer_full was high");
        abort_run();
      end
    end
  end

  initial begin
    mem_pkg::addr_t     a;
    mem_pkg::word_t     d;
    mem_pkg::ls_width_e w;
    mem_pkg::ls_width_e sw;
    rst_in = 1'b1;
    rdy_in = 1'b1;
    io_buffer_full = 1'b0;
    fetch_en = 1'b0;
    fetch_addr = '0;
    ls_en = 1'b0;
    ls_wr = 1'b0;
    ls_width = mem_pkg::LS_W;
    ls_addr = '0;
    ls_wdata = '0;
    for (int i = 0; i < 65536; i++) begin
      ref_mem[i] = 8'(rand_bits(8));
      ram.mem[i] = ref_mem[i];
    end
    repeat (10) @(posedge clk_in);
    rst_in <= 1'b0;
    @(negedge clk_in);
    assert (!fetch_valid && !ls_rdone && !ls_wdone && !mem_wr && mem_a == '0) else begin
      $display("outputs not idle after reset");
      abort_run();
    end

    // cold miss, same-block hit, then a conflicting tag on the same index
    a = rand_bits(13) << 2;
    do_fetch(a, 0);
    do_fetch(a ^ 32'h4, 1);
    do_fetch(a ^ 32'h800, 0);
    do_fetch(a, 0);
    do_fetch(a ^ 32'h4, 1);

    for (int r = 0; r < NUM_RAND; r++) begin
      case (r % 5)
        0:       w = mem_pkg::LS_B;
        1:       w = mem_pkg::LS_H;
        2:       w = mem_pkg::LS_W;
        3:       w = mem_pkg::LS_BU;
        default: w = mem_pkg::LS_HU;
      endcase
      sw = (w == mem_pkg::LS_BU) ? mem_pkg::LS_B : (w == mem_pkg::LS_HU) ? mem_pkg::LS_H : w;
      a = 32'h8000 + (rand_bits(12) << 2);
      if (sw == mem_pkg::LS_B) a = a + rand_bits(2);
      else if (sw == mem_pkg::LS_H) a = a + (rand_bits(1) << 1);
      do_load(w, a);
      do_store(sw, a, rand_bits(32));
      do_load(w, a);
    end

    // output port held off by a full buffer
    d = rand_bits(32);
    @(posedge clk_in);
    io_buffer_full <= 1'b1;
    fork
      do_store(mem_pkg::LS_B, `IO_PORT_ADDR, d);
      begin
        repeat (12) @(posedge clk_in);
        assert (ram.io_count == 0) else begin
          $display("I/O write went out before io_buffer_full fell");
          abort_run();
        end
        io_buffer_full <= 1'b0;
      end
    join
    assert (ram.io_count == 1) else begin
      $display("expected exactly one I/O port write");
      abort_run();
    end
    assert (ram.io_last == d[7:0]) else fail_value("io byte", ram.io_last, d[7:0]);

    for (int k = 0; k < 4; k++) begin
      fork
        do_load(mem_pkg::LS_W, 32'h9000 + (rand_bits(10) << 2));
        do_fetch(32'h4000 + (rand_bits(11) << 2), 2);
        pause_bus(k + 1, 3);
      join
      a = 32'hC000 + (rand_bits(10) << 2);
      fork
        do_store(mem_pkg::LS_W, a, rand_bits(32));
        pause_bus(k + 2, 2);
      join
    end

    // fetch and load strobed on the same edge
    for (int k = 0; k < 4; k++) begin
      fork
        do_fetch(32'h2000 + (rand_bits(11) << 2), 2);
        do_load(mem_pkg::LS_H, 32'hC000 + (rand_bits(11) << 1));
      join
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+src
src/mem_pkg.sv
src/mem_ctrl.sv
src/ins_cache.sv
src/lsu_datapath.sv
src/mem_subsystem.sv
sim/tb_clock.sv
sim/ram_model.sv
sim/mem_tb.sv
